//--- all.f
lspcRegPkg.sv
lspcVramPkg.sv
lspcRegDecode.sv
lspcVramExecute.sv
lspcReadResult.sv
lspcVramPort.sv
tbClockGen.sv
tbLspcVramPort.sv

//--- tbLspcVramPort.sv
/*
  Testbench for the LSPC VRAM port.
  Builds a table of CPU writes, reads, frame strobes and idle gaps,
  with expected read words from a model of the port. One entry is
  driven per clock, and every rdValid is checked for its timing and
  its word against a queue of reads in flight.
*/

`timescale 1ns/100ps

module tbLspcVramPort;

	typedef enum {kindWrite, kindRead, kindFrame, kindIdle} entryKind;

	typedef struct {
		entryKind             kind;
		lspcRegPkg::regOffset off;
		lspcRegPkg::cpuWord   data;
		lspcRegPkg::cpuWord   expVal;
	} stimEntry;

	// Read in flight, with the cycle its response is due
	typedef struct {
		lspcRegPkg::cpuWord value;
		int                 due;
	} pendingRead;

	logic                 CLK;
	logic                 nRESETP;
	logic                 wrStb;
	logic                 rdStb;
	lspcRegPkg::regOffset regAddr;
	lspcRegPkg::cpuWord   wrData;
	logic                 frameStb;
	logic                 rdValid;
	lspcRegPkg::cpuWord   rdData;

	stimEntry   stimTable[$];
	pendingRead pending[$];
	int         cycleCnt   = 0;
	logic       tableReady = 1'b0;
	integer     seed;

	// ==================================================
	// Reference model state
	// ==================================================

	lspcVramPkg::vramAddr mdAddr  = '0;
	lspcVramPkg::vramMod  mdMod   = '0;
	lspcRegPkg::aaSpeedT  mdSpeed = '0;
	lspcRegPkg::aaSpeedT  mdDiv   = '0;
	lspcRegPkg::aaCountT  mdCount = '0;
	logic                 mdDis   = 1'b0;
	lspcRegPkg::cpuWord   lowMem[int];
	lspcRegPkg::cpuWord   highMem[int];

	tbClockGen #(.period(20), .resetCycles(2)) clockGen_i (
		.CLK     (CLK),
		.nRESETP (nRESETP)
	);

	lspcVramPort lspcVramPort_i (
		.CLK      (CLK),
		.nRESETP  (nRESETP),
		.wrStb    (wrStb),
		.rdStb    (rdStb),
		.regAddr  (regAddr),
		.wrData   (wrData),
		.frameStb (frameStb),
		.rdValid  (rdValid),
		.rdData   (rdData)
	);

	function automatic lspcRegPkg::cpuWord randWord();
		return lspcRegPkg::cpuWord'($random(seed));
	endfunction

	// Bit 15 picks the zone, low bits index it
	task automatic vramStore(lspcVramPkg::vramAddr addr, lspcRegPkg::cpuWord data);
		if (addr[lspcVramPkg::zoneSelBit]) begin
			highMem[addr % (1 << lspcVramPkg::defHighAddrBits)] = data;
		end else begin
			lowMem[addr % (1 << lspcVramPkg::defLowAddrBits)] = data;
		end
	endtask

	// Unwritten words are unknown
	function automatic lspcRegPkg::cpuWord vramLoad(lspcVramPkg::vramAddr addr);
		int idx;
		if (addr[lspcVramPkg::zoneSelBit]) begin
			idx = addr % (1 << lspcVramPkg::defHighAddrBits);
			return highMem.exists(idx) ? highMem[idx] : 'x;
		end
		idx = addr % (1 << lspcVramPkg::defLowAddrBits);
		return lowMem.exists(idx) ? lowMem[idx] : 'x;
	endfunction

	task automatic addEntry(entryKind kind, lspcRegPkg::regOffset off,
		lspcRegPkg::cpuWord data, lspcRegPkg::cpuWord expVal);
		stimEntry e;
		e.kind   = kind;
		e.off    = off;
		e.data   = data;
		e.expVal = expVal;
		stimTable.push_back(e);
	endtask

	// ==================================================
	// Table builders, each steps the model
	// ==================================================

	task automatic cpuWrite(lspcRegPkg::regOffset off, lspcRegPkg::cpuWord data);
		case (off)
			lspcRegPkg::offVramAddr: mdAddr = data;
			lspcRegPkg::offVramRw: begin
				vramStore(mdAddr, data);
				mdAddr = mdAddr + mdMod;
			end
			lspcRegPkg::offVramMod: mdMod = data;
			lspcRegPkg::offLspcMode: begin
				mdSpeed = data[15:8];
				mdDis   = data[3];
			end
			default: ;
		endcase
		addEntry(kindWrite, off, data, '0);
	endtask

	task automatic cpuRead(lspcRegPkg::regOffset off);
		lspcRegPkg::cpuWord expVal;
		case (off)
			lspcRegPkg::offVramAddr,
			lspcRegPkg::offVramRw:   expVal = vramLoad(mdAddr);
			lspcRegPkg::offVramMod:  expVal = mdMod;
			lspcRegPkg::offLspcMode: begin
				// Unused mode bits read as zero
				expVal       = '0;
				expVal[15:8] = mdSpeed;
				expVal[3]    = mdDis;
				expVal[2:0]  = mdCount;
			end
			default:                 expVal = '0;
		endcase
		addEntry(kindRead, off, randWord(), expVal);
	endtask

	// Divider runs whether or not animation is disabled
	task automatic frameTick();
		if (mdDiv == mdSpeed) begin
			mdDiv   = '0;
			mdCount = mdCount + 1'b1;
		end else begin
			mdDiv = mdDiv + 1'b1;
		end
		addEntry(kindFrame, '0, randWord(), '0);
	endtask

	task automatic idleGap(int n);
		repeat (n) addEntry(kindIdle, '0, randWord(), '0);
	endtask

	task automatic buildTable();
		lspcVramPkg::vramAddr a;
		lspcVramPkg::vramMod  m;
		lspcRegPkg::cpuWord   w;
		// Reset values
		cpuRead(lspcRegPkg::offVramMod);
		cpuRead(lspcRegPkg::offLspcMode);
		idleGap(2);
		// Store and reload, alternating zones
		for (int i = 0; i < 6; i++) begin
			a = randWord();
			a[lspcVramPkg::zoneSelBit] = i[0];
			cpuWrite(lspcRegPkg::offVramAddr, a);
			cpuWrite(lspcRegPkg::offVramRw, randWord());
			cpuWrite(lspcRegPkg::offVramAddr, a);
			cpuRead(lspcRegPkg::offVramAddr);
			cpuRead(lspcRegPkg::offVramRw);
		end
		// High zone aliases above 2K
		cpuWrite(lspcRegPkg::offVramAddr, 16'h8123);
		cpuWrite(lspcRegPkg::offVramRw, randWord());
		cpuWrite(lspcRegPkg::offVramAddr, 16'hF923);
		cpuRead(lspcRegPkg::offVramRw);
		cpuWrite(lspcRegPkg::offVramRw, randWord());
		cpuWrite(lspcRegPkg::offVramAddr, 16'h8123);
		cpuRead(lspcRegPkg::offVramAddr);
		// Modulo 1, then one that wraps past 16 bits
		for (int k = 0; k < 2; k++) begin
			m = k ? 16'h9123 : 16'h0001;
			a = k ? 16'h2000 : 16'h0100;
			cpuWrite(lspcRegPkg::offVramMod, m);
			cpuWrite(lspcRegPkg::offVramAddr, a);
			repeat (5) cpuWrite(lspcRegPkg::offVramRw, randWord());
			for (int i = 0; i < 5; i++) begin
				cpuWrite(lspcRegPkg::offVramAddr, a);
				cpuRead(lspcRegPkg::offVramRw);
				a = a + m;
			end
		end
		// Modulo readback, dead offsets
		cpuWrite(lspcRegPkg::offVramMod, randWord());
		cpuRead(lspcRegPkg::offVramMod);
		for (int i = 4; i < 8; i++) cpuWrite(lspcRegPkg::regOffset'(i), randWord());
		cpuRead(lspcRegPkg::offVramMod);
		cpuRead(lspcRegPkg::offVramAddr);
		for (int i = 4; i < 8; i++) cpuRead(lspcRegPkg::regOffset'(i));
		// Gaps keep mode accesses and frames in table order
		w = randWord();
		w[15:8] = 8'd2;
		w[3] = 1'b1;
		cpuWrite(lspcRegPkg::offLspcMode, w);
		idleGap(3);
		cpuRead(lspcRegPkg::offLspcMode);
		idleGap(3);
		repeat (6) frameTick();
		cpuRead(lspcRegPkg::offLspcMode);
		idleGap(3);
		// Speed 0 steps every frame, count wraps
		w = randWord();
		w[15:8] = 8'd0;
		w[3] = 1'b0;
		cpuWrite(lspcRegPkg::offLspcMode, w);
		idleGap(3);
		repeat (9) frameTick();
		cpuRead(lspcRegPkg::offLspcMode);
		idleGap(3);
		// Back to back traffic
		cpuWrite(lspcRegPkg::offVramMod, 16'h0000);
		for (int i = 0; i < 8; i++) begin
			cpuWrite(lspcRegPkg::offVramAddr, i[0] ? 16'h0040 : 16'h8040);
			cpuWrite(lspcRegPkg::offVramRw, randWord());
			cpuRead(lspcRegPkg::offVramRw);
			cpuRead(lspcRegPkg::offVramMod);
			cpuWrite(lspcRegPkg::offVramRw, randWord());
			cpuRead(lspcRegPkg::offVramAddr);
		end
		cpuWrite(lspcRegPkg::offVramMod, 16'h0001);
		cpuWrite(lspcRegPkg::offVramAddr, 16'h0300);
		cpuWrite(lspcRegPkg::offVramRw, randWord());
		cpuWrite(lspcRegPkg::offVramRw, randWord());
		cpuWrite(lspcRegPkg::offVramAddr, 16'h0300);
		cpuRead(lspcRegPkg::offVramRw);
		cpuWrite(lspcRegPkg::offVramAddr, 16'h0301);
		cpuRead(lspcRegPkg::offVramRw);
	endtask

	// ==================================================
	// Checks
	// ==================================================

	task automatic abortRun();
		$display("Test FAILED");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic checkWord(string name, lspcRegPkg::cpuWord got, lspcRegPkg::cpuWord exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s = 0x%04h, expected 0x%04h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkValid(logic got, logic exp);
		if (got !== exp) begin
			if (exp) begin
				$display("At %0t ns a read response was due but rdValid stayed low", $time);
			end else begin
				$display("At %0t ns rdValid came high with no read due", $time);
			end
			abortRun();
		end
	endtask

	always @(posedge CLK) begin
		cycleCnt <= cycleCnt + 1;
	end

	// Outputs are stable at the falling edge
	always @(negedge CLK) begin : respMonitor
		logic       dueNow;
		pendingRead slot;
		if (nRESETP) begin
			dueNow = 1'b0;
			if (pending.size() > 0) begin
				dueNow = (pending[0].due == cycleCnt);
			end
			checkValid(rdValid, dueNow);
			if (rdValid) begin
				slot = pending.pop_front();
				checkWord("rdData", rdData, slot.value);
			end
		end
	end

	// ==================================================
	// Stimulus
	// ==================================================

	initial begin : stimulus
		pendingRead slot;
		int         n;
		wrStb    = 1'b0;
		rdStb    = 1'b0;
		regAddr  = '0;
		wrData   = '0;
		frameStb = 1'b0;
		seed     = 32'ha466c2e2;
		buildTable();
		tableReady = 1'b1;
		wait (nRESETP === 1'b1);
		foreach (stimTable[i]) begin
			@(posedge CLK);
			wrStb    <= (stimTable[i].kind == kindWrite);
			rdStb    <= (stimTable[i].kind == kindRead);
			frameStb <= (stimTable[i].kind == kindFrame);
			regAddr  <= stimTable[i].off;
			wrData   <= stimTable[i].data;
			if (stimTable[i].kind == kindRead) begin
				slot.value = stimTable[i].expVal;
				// Counter reads one less here than after this edge
				slot.due   = cycleCnt + 4;
				pending.push_back(slot);
			end
		end
		@(posedge CLK);
		wrStb    <= 1'b0;
		rdStb    <= 1'b0;
		frameStb <= 1'b0;
		// Last read lands within the fixed latency
		n = 0;
		while (n < 5 && pending.size() != 0) begin
			@(posedge CLK);
			n++;
		end
		if (pending.size() == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("%0d reads ended without a response", pending.size());
			abortRun();
		end
	end

	// One clock per entry plus reset and drain margin
	initial begin : watchdog
		wait (tableReady);
		#((stimTable.size() + 50) * 20);
		$display("Watchdog expired before the stimulus table finished");
		abortRun();
	end

endmodule

//--- tbClockGen.sv
/*
  Testbench clock and reset source.
  Free-running clock of the given period, and an active low reset
  held for a number of rising edges after time zero.
*/

`timescale 1ns/100ps

module tbClockGen #(
	parameter int period      = 20,
	parameter int resetCycles = 2
) (
	output logic CLK,
	output logic nRESETP
);

	// Clock starts low
	initial begin
		CLK = 1'b0;
		forever #(period / 2) CLK = ~CLK;
	end

	// Reset released on a rising edge
	initial begin
		nRESETP = 1'b0;
		repeat (resetCycles) @(posedge CLK);
		nRESETP <= 1'b1;
	end

endmodule

//--- lspcVramPort.sv
/*
  Top level of the LSPC CPU-facing VRAM port.
  Chains decode, execute and result. Every CPU access completes
  3 cycles after its strobe, in order. Zone index widths are set
  here and passed down to the execute stage.
*/

`timescale 1ns/100ps

module lspcVramPort #(
	parameter int lowAddrBits  = lspcVramPkg::defLowAddrBits,
	parameter int highAddrBits = lspcVramPkg::defHighAddrBits
) (
	input  logic                 CLK,
	input  logic                 nRESETP,
	input  logic                 wrStb,
	input  logic                 rdStb,
	input  lspcRegPkg::regOffset regAddr,
	input  lspcRegPkg::cpuWord   wrData,
	input  logic                 frameStb,
	output logic                 rdValid,
	output lspcRegPkg::cpuWord   rdData
);

	// Decode to execute
	lspcRegPkg::lspcCmd  decCmd;
	lspcRegPkg::cpuWord  decData;

	// Execute to result
	lspcRegPkg::lspcCmd  exeCmd;
	lspcRegPkg::cpuWord  exeData;
	lspcRegPkg::cpuWord  exeVramData;
	lspcVramPkg::vramMod exeMod;

	// ==================================================
	// Pipeline stages
	// ==================================================

	lspcRegDecode lspcRegDecode_i (
		.CLK     (CLK),
		.nRESETP (nRESETP),
		.wrStb   (wrStb),
		.rdStb   (rdStb),
		.regAddr (regAddr),
		.wrData  (wrData),
		.decCmd  (decCmd),
		.decData (decData)
	);

	lspcVramExecute #(
		.lowAddrBits  (lowAddrBits),
		.highAddrBits (highAddrBits)
	) lspcVramExecute_i (
		.CLK         (CLK),
		.nRESETP     (nRESETP),
		.decCmd      (decCmd),
		.decData     (decData),
		.exeCmd      (exeCmd),
		.exeData     (exeData),
		.exeVramData (exeVramData),
		.exeMod      (exeMod)
	);

	lspcReadResult lspcReadResult_i (
		.CLK         (CLK),
		.nRESETP     (nRESETP),
		.frameStb    (frameStb),
		.exeCmd      (exeCmd),
		.exeData     (exeData),
		.exeVramData (exeVramData),
		.exeMod      (exeMod),
		.rdValid     (rdValid),
		.rdData      (rdData)
	);

endmodule

//--- lspcReadResult.sv
/*
  Result stage of the LSPC VRAM port.
  Holds the mode register and the auto-animation frame divider and
  counter, which run on the per-frame strobe. Read commands leave
  here as an rdValid pulse with the matching word on rdData.
*/

`timescale 1ns/100ps

module lspcReadResult (
	input  logic                CLK,
	input  logic                nRESETP,
	input  logic                frameStb,
	input  lspcRegPkg::lspcCmd  exeCmd,
	input  lspcRegPkg::cpuWord  exeData,
	input  lspcRegPkg::cpuWord  exeVramData,
	input  lspcVramPkg::vramMod exeMod,
	output logic                rdValid,
	output lspcRegPkg::cpuWord  rdData
);

	// Mode register fields
	lspcRegPkg::aaSpeedT aaSpeed;
	logic                aaDisable;

	// Auto-animation state
	lspcRegPkg::aaSpeedT aaDiv;
	lspcRegPkg::aaCountT aaCount;

	// Mode readback word
	lspcRegPkg::cpuWord modeWord;

	// Speed high byte, disable at bit 3, count low bits
	assign modeWord = {aaSpeed, 4'b0000, aaDisable, aaCount};

	// ==================================================
	// Mode register and auto-animation
	// ==================================================

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			aaSpeed   <= '0;
			aaDisable <= 1'b0;
			aaDiv     <= '0;
			aaCount   <= '0;
			rdValid   <= 1'b0;
		end else begin
			if (exeCmd == lspcRegPkg::cmdSetMode) begin
				aaSpeed   <= exeData[15:8];
				aaDisable <= exeData[3];
			end
			// Counter keeps running while disabled
			if (frameStb) begin
				if (aaDiv == aaSpeed) begin
					aaDiv   <= '0;
					aaCount <= lspcRegPkg::aaCountT'(aaCount + 1'b1);
				end else begin
					aaDiv <= lspcRegPkg::aaSpeedT'(aaDiv + 1'b1);
				end
			end
			rdValid <= lspcRegPkg::isReadCmd(exeCmd);
		end
	end

	// ==================================================
	// Read response
	// ==================================================

	always_ff @(posedge CLK) begin
		case (exeCmd)
			lspcRegPkg::cmdReadVram: rdData <= exeVramData;
			lspcRegPkg::cmdReadMod:  rdData <= lspcRegPkg::cpuWord'(exeMod);
			lspcRegPkg::cmdReadMode: rdData <= modeWord;
			lspcRegPkg::cmdReadZero: rdData <= '0;
			// Holds last value between reads
			default: ;
		endcase
	end

endmodule

//--- lspcVramExecute.sv
/*
  Execute stage of the LSPC VRAM port.
  Holds the VRAM address and modulo registers and both VRAM zones.
  A VRAMRW write stores its word at the current address, then steps
  the address by the modulo. Every cycle the word at the current
  address is read out for the result stage. One cycle of latency.
*/

`timescale 1ns/100ps

module lspcVramExecute #(
	parameter int lowAddrBits  = 15,
	parameter int highAddrBits = 11
) (
	input  logic                CLK,
	input  logic                nRESETP,
	input  lspcRegPkg::lspcCmd  decCmd,
	input  lspcRegPkg::cpuWord  decData,
	output lspcRegPkg::lspcCmd  exeCmd,
	output lspcRegPkg::cpuWord  exeData,
	output lspcRegPkg::cpuWord  exeVramData,
	output lspcVramPkg::vramMod exeMod
);

	localparam int lowWords  = 1 << lowAddrBits;
	localparam int highWords = 1 << highAddrBits;

	// Address and modulo registers
	lspcVramPkg::vramAddr addrReg;
	lspcVramPkg::vramMod  modReg;
	lspcVramPkg::vramAddr autoIncAddr;

	// Zone arrays
	lspcRegPkg::cpuWord lowZone  [0:lowWords-1];
	lspcRegPkg::cpuWord highZone [0:highWords-1];

	// Zone indexes from the current address
	logic [lowAddrBits-1:0]  lowIdx;
	logic [highAddrBits-1:0] highIdx;
	logic                    highSel;

	// Registered zone read ports
	lspcRegPkg::cpuWord lowRdData;
	lspcRegPkg::cpuWord highRdData;
	logic               highSelRd;

	assign lowIdx  = addrReg[lowAddrBits-1:0];
	assign highIdx = addrReg[highAddrBits-1:0];
	assign highSel = addrReg[lspcVramPkg::zoneSelBit];

	// Modulo step, wraps at 16 bits
	assign autoIncAddr = addrReg + modReg;

	// ==================================================
	// Control registers
	// ==================================================

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			exeCmd  <= lspcRegPkg::cmdIdle;
			addrReg <= '0;
			modReg  <= '0;
		end else begin
			exeCmd <= decCmd;
			case (decCmd)
				lspcRegPkg::cmdSetAddr:   addrReg <= lspcVramPkg::vramAddr'(decData);
				lspcRegPkg::cmdSetMod:    modReg  <= lspcVramPkg::vramMod'(decData);
				// Step after the write lands at the old address
				lspcRegPkg::cmdWriteVram: addrReg <= autoIncAddr;
				default: ;
			endcase
		end
	end

	// ==================================================
	// VRAM zones
	// ==================================================

	// Writes go to the zone picked by bit 15
	always_ff @(posedge CLK) begin
		if (decCmd == lspcRegPkg::cmdWriteVram) begin
			if (highSel) begin
				highZone[highIdx] <= decData;
			end else begin
				lowZone[lowIdx] <= decData;
			end
		end
	end

	// Read both zones at the current address
	// earlier writes have already landed
	always_ff @(posedge CLK) begin
		lowRdData  <= lowZone[lowIdx];
		highRdData <= highZone[highIdx];
		highSelRd  <= highSel;
		exeData    <= decData;
	end

	// Zone mux on the registered select
	assign exeVramData = highSelRd ? highRdData : lowRdData;

	// Modulo goes on for readback
	assign exeMod = modReg;

	// ==================================================
	// Checks
	// ==================================================

	// A VRAMRW write needs a known address to pick zone and index
	assert property (@(posedge CLK) disable iff (!nRESETP)
		(decCmd == lspcRegPkg::cmdWriteVram) |-> !$isunknown(addrReg))
		else $error("VRAM write with unknown address");

endmodule

//--- lspcRegDecode.sv
/*
  Decode stage of the LSPC VRAM port.
  Turns a single-cycle CPU write or read strobe and its word
  offset into a pipeline command, registered together with the
  write data. One cycle of latency, no back-pressure.
*/

`timescale 1ns/100ps

module lspcRegDecode (
	input  logic                 CLK,
	input  logic                 nRESETP,
	input  logic                 wrStb,
	input  logic                 rdStb,
	input  lspcRegPkg::regOffset regAddr,
	input  lspcRegPkg::cpuWord   wrData,
	output lspcRegPkg::lspcCmd   decCmd,
	output lspcRegPkg::cpuWord   decData
);

	lspcRegPkg::lspcCmd nextCmd;

	// ==================================================
	// Strobe to command mapping
	// ==================================================

	always_comb begin
		nextCmd = lspcRegPkg::cmdIdle;
		if (wrStb) begin
			case (regAddr)
				lspcRegPkg::offVramAddr: nextCmd = lspcRegPkg::cmdSetAddr;
				lspcRegPkg::offVramRw:   nextCmd = lspcRegPkg::cmdWriteVram;
				lspcRegPkg::offVramMod:  nextCmd = lspcRegPkg::cmdSetMod;
				lspcRegPkg::offLspcMode: nextCmd = lspcRegPkg::cmdSetMode;
				// Unmapped offsets swallow the write
				default:                 nextCmd = lspcRegPkg::cmdIdle;
			endcase
		end else if (rdStb) begin
			case (regAddr)
				// Address and RW offsets both return VRAM
				lspcRegPkg::offVramAddr,
				lspcRegPkg::offVramRw:   nextCmd = lspcRegPkg::cmdReadVram;
				lspcRegPkg::offVramMod:  nextCmd = lspcRegPkg::cmdReadMod;
				lspcRegPkg::offLspcMode: nextCmd = lspcRegPkg::cmdReadMode;
				default:                 nextCmd = lspcRegPkg::cmdReadZero;
			endcase
		end
	end

	// Command register
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			decCmd <= lspcRegPkg::cmdIdle;
		end else begin
			decCmd <= nextCmd;
		end
	end

	// Write data rides along with its command
	always_ff @(posedge CLK) begin
		decData <= wrData;
	end

	// ==================================================
	// Checks
	// ==================================================

	// CPU never reads and writes in the same cycle
	assert property (@(posedge CLK) disable iff (!nRESETP)
		!(wrStb && rdStb))
		else $error("wrStb and rdStb high together");

endmodule

//--- lspcVramPkg.sv
/*
  VRAM side types of the LSPC VRAM port.
  Address and modulo words, plus the zone split of the address
  space. The top level takes the default zone index widths from
  here and hands them to the execute stage as parameters.
*/

package lspcVramPkg;

	// ==================================================
	// VRAM words
	// ==================================================

	// Current CPU access address
	typedef logic [15:0] vramAddr;

	// Auto-increment step, added with 16-bit wraparound
	typedef logic [15:0] vramMod;

	// ==================================================
	// Zone selection
	// ==================================================

	// Address bit that picks the high (fast) zone
	localparam int zoneSelBit = 15;

	// Low zone index width, 32K words
	localparam int defLowAddrBits = 15;

	// High zone index width, 2K words
	// upper address bits alias onto these
	localparam int defHighAddrBits = 11;

endpackage

//--- lspcRegPkg.sv
/*
  CPU side register map of the LSPC VRAM port.
  Holds the word offsets, the command set that flows down the
  decode, execute and result stages, and the data word types.
  Users reference items with lspcRegPkg:: scoped names.
*/

package lspcRegPkg;

	// ==================================================
	// Data word types
	// ==================================================

	// CPU data bus word
	typedef logic [15:0] cpuWord;

	// Word offset, CPU address bits 3 to 1
	typedef logic [2:0] regOffset;

	// Frames between animation steps
	typedef logic [7:0] aaSpeedT;

	// Auto-animation tile index
	typedef logic [2:0] aaCountT;

	// ==================================================
	// Register map
	// ==================================================

	localparam regOffset offVramAddr = 3'd0;  // REG_VRAMADDR
	localparam regOffset offVramRw   = 3'd1;  // REG_VRAMRW
	localparam regOffset offVramMod  = 3'd2;  // REG_VRAMMOD
	localparam regOffset offLspcMode = 3'd3;  // REG_LSPCMODE

	// Pipeline commands
	typedef enum logic [3:0] {
		cmdIdle      = 4'd0,
		cmdSetAddr   = 4'd1,
		cmdWriteVram = 4'd2,
		cmdSetMod    = 4'd3,
		cmdSetMode   = 4'd4,
		cmdReadVram  = 4'd5,
		cmdReadMod   = 4'd6,
		cmdReadMode  = 4'd7,
		cmdReadZero  = 4'd8
	} lspcCmd;

	// True for every command that returns a word to the CPU
	function automatic logic isReadCmd(input lspcCmd cmd);
		return (cmd == cmdReadVram) || (cmd == cmdReadMod) ||
			(cmd == cmdReadMode) || (cmd == cmdReadZero);
	endfunction

endpackage
